// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_tensor_octet_core
FILELIST  := tensor_octet_core.f
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tensor_octet_core.f ====
verilog/tensor_pkg.sv
verilog/sync_fifo.sv
verilog/operand_stage.sv
verilog/octet_dpu.sv
verilog/writeback_stage.sv
verilog/tensor_octet_core.sv
testbench/tb_tensor_octet_core.sv

// ==== testbench/tb_tensor_octet_core.sv ====
`timescale 1ns/1ps

module tb_tensor_octet_core
    import tensor_pkg::*;
();
    localparam int TIMEOUT = 200;

    logic    clk;
    logic    reset;
    logic    issue_valid;
    logic    issue_ready;
    issue_t  issue;
    logic    commit_valid;
    logic    commit_ready;
    commit_t commit;

    issue_t      issue_list [$];
    commit_t     expect_list [$];
    int          error_count = 0;
    int          timeout_count = 0;
    int          commit_count = 0;
    int          commit_target = 0;
    int          stall_cycles = 0;
    bit          aborted = 0;
    int          ready_mode = 0;
    int          hold_left = 0;
    logic [31:0] lcg_state = 32'hda877569;
    commit_t     held_commit;
    bit          held_valid = 0;

    tensor_octet_core #(
        .NUM_WARPS   (4),
        .ISSUE_DEPTH (4),
        .DPU_LATENCY (3)
    ) u_tensor_octet_core (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue        (issue),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // mode 0 keeps commit_ready high, mode 1 holds it low and then goes random
    initial begin
        int mode_now;
        commit_ready = 1'b0;
        forever begin
            @(posedge clk);
            mode_now = ready_mode;
            if (mode_now == 1 && hold_left > 0) begin
                hold_left--;
            end
            #1;
            if (mode_now == 0) begin
                commit_ready = 1'b1;
            end else if (hold_left > 0) begin
                commit_ready = 1'b0;
            end else begin
                lcg_state = lcg_next(lcg_state);
                commit_ready = lcg_state[31];
            end
        end
    end

    task automatic compare_beat(input commit_t exp);
        if (commit.wid !== exp.wid || commit.rd !== exp.rd || commit.beat !== exp.beat) begin
            $display("CHECK FAILED at %0t: beat %0d header %0d %0d %0d, expected %0d %0d %0d",
                     $time, commit_count, commit.wid, commit.rd, commit.beat,
                     exp.wid, exp.rd, exp.beat);
            error_count++;
        end
        for (int l = 0; l < LANES; l++) begin
            if (commit.data[l] !== exp.data[l]) begin
                $display("CHECK FAILED at %0t: beat %0d lane %0d got %h, expected %h",
                         $time, commit_count, l, commit.data[l], exp.data[l]);
                error_count++;
            end
        end
    endtask

    // sampled at the falling edge while inputs are steady
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (held_valid && (!commit_valid || commit !== held_commit)) begin
                    $display("CHECK FAILED at %0t: commit changed while commit_ready was low",
                             $time);
                    error_count++;
                end
                held_valid  = commit_valid && !commit_ready;
                held_commit = commit;
                if (commit_valid && commit_ready) begin
                    if (commit_count >= commit_target) begin
                        $display("unexpected commit beat at %0t beyond the expected ones", $time);
                        error_count++;
                    end else begin
                        compare_beat(expect_list[commit_count % expect_list.size()]);
                    end
                    commit_count++;
                end
            end
        end
    end

    task automatic read_lanes(input int fd, output lane_vec_t v, inout int got);
        logic [31:0] w;
        for (int l = 0; l < LANES; l++) begin
            w = '0;
            got += $fscanf(fd, "%h", w);
            v[l] = w;
        end
    endtask

    task automatic read_trace();
        int            fd;
        int            n;
        logic [63:0]   tag;
        logic [2047:0] line_buf;
        logic [31:0]   f0;
        logic [31:0]   f1;
        logic [31:0]   f2;
        logic [31:0]   f3;
        issue_t        ins;
        commit_t       exp;
        fd = $fopen("testbench/tensor_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            error_count++;
            aborted = 1;
            return;
        end
        while (!$feof(fd)) begin
            tag = '0;
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            if (tag == "#") begin
                n = $fgets(line_buf, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                ins.wid          = wid_t'(f0);
                ins.rd           = rd_t'(f1);
                ins.step         = step_t'(f2);
                ins.last_in_pair = f3[0];
                read_lanes(fd, ins.a, n);
                read_lanes(fd, ins.b, n);
                read_lanes(fd, ins.c, n);
                // four header fields and three lane vectors
                if (n != 4 + 3 * LANES) begin
                    $display("an issue record in the trace file is incomplete");
                    error_count++;
                    aborted = 1;
                end
                issue_list.push_back(ins);
            end else if (tag == "C") begin
                n = $fscanf(fd, "%h %h %h", f0, f1, f2);
                exp.wid  = wid_t'(f0);
                exp.rd   = rd_t'(f1);
                exp.beat = f2[0];
                read_lanes(fd, exp.data, n);
                if (n != 3 + LANES) begin
                    $display("a commit record in the trace file is incomplete");
                    error_count++;
                    aborted = 1;
                end
                expect_list.push_back(exp);
            end else begin
                $display("unknown record type in the trace file");
                error_count++;
            end
        end
        $fclose(fd);
        if (issue_list.size() == 0 || expect_list.size() == 0) begin
            $display("the trace file holds no issue or no commit records");
            error_count++;
            aborted = 1;
        end
    endtask

    // called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic send_issue(input issue_t ins);
        int waited;
        waited      = 0;
        issue       = ins;
        issue_valid = 1'b1;
        while (!issue_ready && waited < TIMEOUT) begin
            stall_cycles++;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!issue_ready) begin
            $display("timeout at %0t: issue_ready stayed low", $time);
            timeout_count++;
            aborted = 1;
        end else begin
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b0;
    endtask

    task automatic send_trace();
        foreach (issue_list[i]) begin
            if (!aborted) begin
                send_issue(issue_list[i]);
            end
        end
    endtask

    task automatic wait_for_commits();
        int waited;
        waited = 0;
        while (commit_count < commit_target && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (commit_count < commit_target) begin
            $display("timeout at %0t: only %0d of %0d commit beats arrived",
                     $time, commit_count, commit_target);
            timeout_count++;
            aborted = 1;
        end
    endtask

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue       = '0;
        read_trace();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        if (commit_valid !== 1'b0 || issue_ready !== 1'b1) begin
            $display("CHECK FAILED at %0t: after reset commit_valid %b issue_ready %b",
                     $time, commit_valid, issue_ready);
            error_count++;
        end

        // ordered run with the commit side always ready
        if (!aborted) begin
            commit_target = expect_list.size();
            send_trace();
            wait_for_commits();
        end

        // back-to-back replays while the commit side is first blocked, then random
        if (!aborted) begin
            commit_target = 4 * expect_list.size();
            stall_cycles  = 0;
            hold_left     = 40;
            ready_mode    = 1;
            for (int k = 0; k < 3; k++) begin
                send_trace();
            end
            wait_for_commits();
            if (!aborted && stall_cycles == 0) begin
                $display("issue_ready never dropped while the commit side was blocked");
                error_count++;
            end
        end

        if (!aborted && commit_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t: commit_valid still high after the last beat", $time);
            error_count++;
        end

        $display("%0d errors, %0d timeouts, %0d of %0d commit beats checked",
                 error_count, timeout_count, commit_count, commit_target);
        if (error_count == 0 && timeout_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== testbench/tensor_trace.txt ====
# I wid rd step last_in_pair a0..a7 b0..b7 c0..c7 (issue record, hex)
# C wid rd beat d0..d7 (expected commit beat, hex, listed in commit order)
I 0 01 0 0 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 1000 1100 1200 1300 1400 1500 1600 1700
I 0 05 1 1 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 2000 2100 2200 2300 2400 2500 2600 2700
I 0 02 1 0 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 3000 3100 3200 3300 3400 3500 3600 3700
I 0 06 2 1 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 4000 4100 4200 4300 4400 4500 4600 4700
I 3 03 2 0 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 5000 5100 5200 5300 5400 5500 5600 5700
I 3 07 3 1 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 6000 6100 6200 6300 6400 6500 6600 6700
I 0 04 3 0 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 7000 7100 7200 7300 7400 7500 7600 7700
I 0 08 0 1 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 ffffffe0 ffffffe1 ffffffe2 ffffffe3 ffffffe4 ffffffe5 ffffffe6 ffffffe7
I 1 0a 0 0 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 9000 9100 9200 9300 9400 9500 9600 9700
I 2 0b 3 0 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 a000 a100 a200 a300 a400 a500 a600 a700
I 2 0d 1 1 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 b000 b100 b200 b300 b400 b500 b600 b700
I 1 0c 2 1 8 7 6 5 4 3 2 1 8 7 6 5 4 3 2 1 c000 c100 c200 c300 c400 c500 c600 c700
C 0 05 0 1031 112a 1227 1324 1415 150e 161b 1718
C 0 05 1 202c 2127 2222 2321 2418 2513 261e 271d
C 0 06 0 3023 3120 3219 331a 3417 3514 361d 371e
C 0 06 1 401e 411d 4214 4317 441a 4519 4620 4723
C 3 07 0 501d 511e 5213 5318 5421 5522 5627 572c
C 3 07 1 6018 611b 620e 6315 6424 6527 662a 6731
C 0 08 0 704f 714c 7245 7346 7443 7540 7649 774a
C 0 08 1 2a 2a 22 26 2a 2a 32 36
C 2 0d 0 a01b a118 a215 a316 a40f a50c a619 a71a
C 2 0d 1 b018 b117 b212 b315 b414 b513 b61e b721
C 1 0c 0 9021 911e 9213 9314 9415 9512 9617 9718
C 1 0c 1 c01a c119 c20c c30f c416 c515 c618 c71b

// ==== verilog/octet_dpu.sv ====
`timescale 1ns/1ps

module octet_dpu import tensor_pkg::*; #(
    parameter int DPU_LATENCY = 3
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    output logic     req_ready,
    input  dpu_req_t req,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output dpu_rsp_t rsp
);
    localparam int L = DPU_LATENCY;

    // first stage holds both partial products next to C
    typedef struct packed {
        wid_t      wid;
        rd_t       rd;
        acc_tile_t c;
        acc_tile_t p0;
        acc_tile_t p1;
    } prod_t;

    logic [L-1:0] stage_valid;
    logic         advance;
    prod_t        prod_in;
    prod_t        prod_q;
    dpu_rsp_t     sum_stage;

    // the whole pipe freezes while the last stage is blocked
    assign advance   = !stage_valid[L-1] || rsp_ready;
    assign req_ready = advance;
    assign rsp_valid = stage_valid[L-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= L'({stage_valid, req_valid});
        end
    end

    always_comb begin
        prod_in.wid = req.wid;
        prod_in.rd  = req.rd;
        prod_in.c   = req.c_tile;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                prod_in.p0[r][c] = req.a_tile[r][0] * req.b_tile[0][c];
                prod_in.p1[r][c] = req.a_tile[r][1] * req.b_tile[1][c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            prod_q <= prod_in;
        end
    end

    // integer sums wrap modulo 2^32
    always_comb begin
        sum_stage.wid = prod_q.wid;
        sum_stage.rd  = prod_q.rd;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                sum_stage.d_tile[r][c] = prod_q.c[r][c] + prod_q.p0[r][c] + prod_q.p1[r][c];
            end
        end
    end

    if (L == 1) begin : g_direct
        assign rsp = sum_stage;
    end else begin : g_delay
        dpu_rsp_t delay_q [L-1];

        always_ff @(posedge clk) begin
            if (advance) begin
                delay_q[0] <= sum_stage;
                for (int k = 1; k < L - 1; k++) begin
                    delay_q[k] <= delay_q[k-1];
                end
            end
        end

        assign rsp = delay_q[L-2];
    end

endmodule

// ==== verilog/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage import tensor_pkg::*; #(
    parameter int NUM_WARPS   = 4,
    parameter int ISSUE_DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     issue_valid,
    output logic     issue_ready,
    input  issue_t   issue,
    output logic     dpu_valid,
    input  logic     dpu_ready,
    output dpu_req_t dpu_req
);
    localparam int IDX_W = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;

    // the lanes one instruction contributes to a pair
    typedef struct packed {
        half4_t    a;
        half4_t    b;
        lane_vec_t c;
    } half_t;

    logic                 q_push;
    logic                 q_pop;
    logic                 q_empty;
    logic                 q_full;
    issue_t               head;
    logic                 head_valid;
    logic [IDX_W-1:0]     head_idx;
    logic                 first_fire;
    logic                 second_fire;
    half_t                cur_half;
    half_t                buf_half;
    half_t                warp_buf [NUM_WARPS];
    logic [NUM_WARPS-1:0] pending;

    function automatic half_t decode_half(input issue_t ins);
        half_t h;
        // A takes lanes 0,1,4,5 or 2,3,6,7
        if (ins.step[0]) begin
            h.a = {ins.a[7], ins.a[6], ins.a[3], ins.a[2]};
        end else begin
            h.a = {ins.a[5], ins.a[4], ins.a[1], ins.a[0]};
        end
        h.b = ins.step[1] ? ins.b[7:4] : ins.b[3:0];
        h.c = ins.c;
        return h;
    endfunction

    // decouples instruction arrival from the DPU
    sync_fifo #(
        .WIDTH ($bits(issue_t)),
        .DEPTH (ISSUE_DEPTH)
    ) u_issue_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (q_push),
        .pop      (q_pop),
        .data_in  (issue),
        .data_out (head),
        .empty    (q_empty),
        .full     (q_full)
    );

    assign issue_ready = !q_full;
    assign q_push      = issue_valid && issue_ready;

    assign head_valid  = !q_empty;
    assign head_idx    = head.wid[IDX_W-1:0];

    // a first instruction never waits, a second one waits on the DPU
    assign first_fire  = head_valid && !head.last_in_pair;
    assign dpu_valid   = head_valid && head.last_in_pair;
    assign second_fire = dpu_valid && dpu_ready;
    assign q_pop       = first_fire || second_fire;

    assign cur_half = decode_half(head);
    assign buf_half = warp_buf[head_idx];

    always_ff @(posedge clk) begin
        if (first_fire) begin
            warp_buf[head_idx] <= cur_half;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (first_fire) begin
            pending[head_idx] <= 1'b1;
        end else if (second_fire) begin
            pending[head_idx] <= 1'b0;
        end
    end

    // stored half goes in column/row 0, current half in column/row 1
    always_comb begin
        int lane;
        dpu_req.wid = head.wid;
        dpu_req.rd  = head.rd;
        for (int r = 0; r < 4; r++) begin
            dpu_req.a_tile[r][0] = buf_half.a[r];
            dpu_req.a_tile[r][1] = cur_half.a[r];
        end
        dpu_req.b_tile[0] = buf_half.b;
        dpu_req.b_tile[1] = cur_half.b;
        // rows 0..3 draw on lanes 0,1,4,5 and those lanes plus two
        for (int r = 0; r < 4; r++) begin
            lane = (r < 2) ? r : r + 2;
            dpu_req.c_tile[r][0] = buf_half.c[lane];
            dpu_req.c_tile[r][1] = cur_half.c[lane];
            dpu_req.c_tile[r][2] = buf_half.c[lane + 2];
            dpu_req.c_tile[r][3] = cur_half.c[lane + 2];
        end
    end

    wid_in_range: assert property (@(posedge clk) disable iff (reset)
        q_push |-> (int'(issue.wid) < NUM_WARPS))
        else $error("operand_stage: wid out of range");
    second_has_first: assert property (@(posedge clk) disable iff (reset)
        dpu_valid |-> pending[head_idx])
        else $error("operand_stage: second instruction without a buffered first");

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // show-ahead read of the oldest entry
    assign data_out = mem[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("sync_fifo: push while full");
    no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule

// ==== verilog/tensor_octet_core.sv ====
`timescale 1ns/1ps

module tensor_octet_core import tensor_pkg::*; #(
    parameter int NUM_WARPS   = 4,
    parameter int ISSUE_DEPTH = 4,
    parameter int DPU_LATENCY = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    issue_valid,
    output logic    issue_ready,
    input  issue_t  issue,
    output logic    commit_valid,
    input  logic    commit_ready,
    output commit_t commit
);
    logic     dpu_valid;
    logic     dpu_ready;
    dpu_req_t dpu_req;
    logic     rsp_valid;
    logic     rsp_ready;
    dpu_rsp_t rsp;

    operand_stage #(
        .NUM_WARPS   (NUM_WARPS),
        .ISSUE_DEPTH (ISSUE_DEPTH)
    ) u_operand_stage (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue       (issue),
        .dpu_valid   (dpu_valid),
        .dpu_ready   (dpu_ready),
        .dpu_req     (dpu_req)
    );

    octet_dpu #(
        .DPU_LATENCY (DPU_LATENCY)
    ) u_octet_dpu (
        .clk       (clk),
        .reset     (reset),
        .req_valid (dpu_valid),
        .req_ready (dpu_ready),
        .req       (dpu_req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    writeback_stage #(
        .DPU_LATENCY (DPU_LATENCY)
    ) u_writeback_stage (
        .clk          (clk),
        .reset        (reset),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp          (rsp),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

// ==== verilog/tensor_pkg.sv ====
package tensor_pkg;

    // element width and octet geometry
    localparam int WORD_W    = 32;
    localparam int LANES     = 8;
    localparam int MAX_WARPS = 8;

    typedef logic [$clog2(MAX_WARPS)-1:0] wid_t;
    typedef logic [4:0]                   rd_t;

    // bit 0 picks the A lane group, bit 1 picks the B lane group
    typedef logic [1:0] step_t;

    typedef logic [WORD_W-1:0] word_t;

    // one word per lane
    typedef word_t [LANES-1:0] lane_vec_t;
    typedef word_t [3:0]       half4_t;

    // tiles are indexed [row][col]
    typedef word_t [3:0][1:0] a_tile_t;
    typedef word_t [1:0][3:0] b_tile_t;
    typedef word_t [3:0][3:0] acc_tile_t;

    // one matrix instruction as seen on the 8 lanes
    typedef struct packed {
        wid_t      wid;
        rd_t       rd;
        step_t     step;
        logic      last_in_pair;
        lane_vec_t a;
        lane_vec_t b;
        lane_vec_t c;
    } issue_t;

    typedef struct packed {
        wid_t      wid;
        rd_t       rd;
        a_tile_t   a_tile;
        b_tile_t   b_tile;
        acc_tile_t c_tile;
    } dpu_req_t;

    typedef struct packed {
        wid_t      wid;
        rd_t       rd;
        acc_tile_t d_tile;
    } dpu_rsp_t;

    // one writeback beat, half of the D tile
    typedef struct packed {
        wid_t      wid;
        rd_t       rd;
        logic      beat;
        lane_vec_t data;
    } commit_t;

endpackage

// ==== verilog/writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage import tensor_pkg::*; #(
    parameter int DPU_LATENCY = 3
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     rsp_valid,
    output logic     rsp_ready,
    input  dpu_rsp_t rsp,
    output logic     commit_valid,
    input  logic     commit_ready,
    output commit_t  commit
);
    // room for a full DPU burst while the lanes drain two beats per tile
    localparam int RQ_DEPTH = 2 * DPU_LATENCY;

    logic     rq_push;
    logic     rq_pop;
    logic     rq_empty;
    logic     rq_full;
    dpu_rsp_t head;
    logic     commit_fire;
    logic     beat_q;

    sync_fifo #(
        .WIDTH ($bits(dpu_rsp_t)),
        .DEPTH (RQ_DEPTH)
    ) u_result_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (rq_push),
        .pop      (rq_pop),
        .data_in  (rsp),
        .data_out (head),
        .empty    (rq_empty),
        .full     (rq_full)
    );

    assign rsp_ready    = !rq_full;
    assign rq_push      = rsp_valid && rsp_ready;

    assign commit_valid = !rq_empty;
    assign commit_fire  = commit_valid && commit_ready;
    // a tile leaves only after its second beat
    assign rq_pop       = commit_fire && beat_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_q <= 1'b0;
        end else if (commit_fire) begin
            beat_q <= !beat_q;
        end
    end

    // lanes 0..3 carry rows 0,1 and lanes 4..7 rows 2,3
    // beat 0 sends columns 0 and 2, beat 1 columns 1 and 3
    always_comb begin
        int row;
        int col;
        commit.wid  = head.wid;
        commit.rd   = head.rd;
        commit.beat = beat_q;
        for (int l = 0; l < LANES; l++) begin
            row = (l < 4) ? (l % 2) : 2 + (l % 2);
            col = 2 * ((l / 2) % 2) + int'(beat_q);
            commit.data[l] = head.d_tile[row][col];
        end
    end

    commit_hold: assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit)))
        else $error("writeback_stage: commit changed while stalled");

endmodule
